// ==== source/branchResolver.sv ====
`timescale 1ns/1ps

module branchResolver #(
  parameter int xlen = 64
) (
  input  decodeTypesPkg::instFormatT format,
  input  logic [2:0]                 func3,
  input  logic                       jalrFlag,
  input  logic [xlen-1:0]            pc,
  input  logic [xlen-1:0]            imm,
  input  logic [xlen-1:0]            rs1Data,
  input  logic [xlen-1:0]            rs2Data,
  output execTypesPkg::npcRequestT   npcReq
);
  import decodeTypesPkg::*;
  import execTypesPkg::*;

  logic equal;
  logic lessSigned;
  logic lessUnsigned;
  logic taken;
  jumpKindT kind;

  assign equal = rs1Data == rs2Data;
  assign lessSigned = $signed(rs1Data) < $signed(rs2Data);
  assign lessUnsigned = rs1Data < rs2Data;

  // 010 and 011 are not branches
  always_comb begin
    case (func3)
      3'b000: taken = equal;
      3'b001: taken = !equal;
      3'b100: taken = lessSigned;
      3'b101: taken = !lessSigned;
      3'b110: taken = lessUnsigned;
      3'b111: taken = !lessUnsigned;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (jalrFlag) begin
      kind = jumpJalr;
    end else if (format == jFormat) begin
      kind = jumpJal;
    end else if (format == bFormat && taken) begin
      kind = jumpBranch;
    end else begin
      kind = jumpNone;
    end
  end

  assign npcReq = '{
    kind: kind,
    pc: xlenMax'(pc),
    imm: xlenMax'(imm),
    rs1Data: xlenMax'(rs1Data)
  };

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage #(
  parameter int xlen = 64
) (
  input  logic                      clock,
  input  logic                      reset,
  input  decodeTypesPkg::instT      inst,
  input  logic [xlen-1:0]           pc,
  input  logic                      fetchValid,
  input  logic [xlen-1:0]           regRdata1,
  input  logic [xlen-1:0]           regRdata2,
  input  execTypesPkg::bypassT      bypass,
  input  logic                      busy1,
  input  logic                      busy2,
  input  logic                      exReady,
  output decodeTypesPkg::regAddrT   raddr1,
  output decodeTypesPkg::regAddrT   raddr2,
  output execTypesPkg::idexBundleT  idex,
  output logic                      idexValid,
  output execTypesPkg::npcRequestT  npcReq,
  output logic                      npcValid,
  output logic                      ifReady,
  output logic                      sbValid,
  output logic                      sbWen,
  output decodeTypesPkg::regAddrT   sbWaddr
);
  import decodeTypesPkg::*;
  import execTypesPkg::*;

  instFormatT format;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] rs1Data;
  logic [xlen-1:0] rs2Data;
  logic [xlen-1:0] aluRd1;
  logic [xlen-1:0] aluRd2;
  aluOpT aluOp;
  logic wen;
  logic readFlag;
  logic writeFlag;
  logic jalrFlag;
  logic shamtFlag;
  storeMaskT storeMask;
  regAddrT waddr;
  idexBundleT bundle;

  assign raddr1 = inst[19:15];
  assign raddr2 = inst[24:20];
  assign waddr = inst[11:7];
  assign sbWaddr = waddr;

  instDecoder #(.xlen(xlen)) u_instDecoder (
    .inst      (inst),
    .format    (format),
    .imm       (imm),
    .aluOp     (aluOp),
    .wen       (wen),
    .readFlag  (readFlag),
    .writeFlag (writeFlag),
    .jalrFlag  (jalrFlag),
    .shamtFlag (shamtFlag),
    .storeMask (storeMask)
  );

  operandSelect #(.xlen(xlen)) u_operandSelect (
    .format    (format),
    .opcode    (inst[6:0]),
    .pc        (pc),
    .imm       (imm),
    .shamtFlag (shamtFlag),
    .jalrFlag  (jalrFlag),
    .regRdata1 (regRdata1),
    .regRdata2 (regRdata2),
    .busy1     (busy1),
    .busy2     (busy2),
    .bypass    (bypass),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data),
    .aluRd1    (aluRd1),
    .aluRd2    (aluRd2)
  );

  branchResolver #(.xlen(xlen)) u_branchResolver (
    .format   (format),
    .func3    (inst[14:12]),
    .jalrFlag (jalrFlag),
    .pc       (pc),
    .imm      (imm),
    .rs1Data  (rs1Data),
    .rs2Data  (rs2Data),
    .npcReq   (npcReq)
  );

  // narrow data is zero-extended into the wide bundle fields
  assign bundle = '{
    pc: xlenMax'(pc),
    inst: inst,
    aluOp: aluOp,
    aluRd1: xlenMax'(aluRd1),
    aluRd2: xlenMax'(aluRd2),
    rs2Data: xlenMax'(rs2Data),
    imm: xlenMax'(imm),
    waddr: waddr,
    wen: wen,
    readFlag: readFlag,
    writeFlag: writeFlag,
    storeMask: storeMask,
    jalrFlag: jalrFlag,
    abort: (format == badFormat)
  };

  issueControl #(.xlen(xlen)) u_issueControl (
    .clock      (clock),
    .reset      (reset),
    .fetchValid (fetchValid),
    .busy1      (busy1),
    .busy2      (busy2),
    .pass1      (bypass.pass1),
    .pass2      (bypass.pass2),
    .exReady    (exReady),
    .bundleIn   (bundle),
    .ifReady    (ifReady),
    .npcValid   (npcValid),
    .sbValid    (sbValid),
    .sbWen      (sbWen),
    .idex       (idex),
    .idexValid  (idexValid)
  );

endmodule

// ==== source/decodeTypesPkg.sv ====
package decodeTypesPkg;

  localparam int instWidth = 32;
  localparam int regAddrWidth = 5;
  localparam int opcodeWidth = 7;

  typedef logic [instWidth-1:0] instT;
  typedef logic [regAddrWidth-1:0] regAddrT;
  typedef logic [opcodeWidth-1:0] opcodeT;

  // major opcodes of the base integer set
  localparam opcodeT opLoad = 7'b0000011;
  localparam opcodeT opImm = 7'b0010011;
  localparam opcodeT opAuipc = 7'b0010111;
  localparam opcodeT opStore = 7'b0100011;
  localparam opcodeT opReg = 7'b0110011;
  localparam opcodeT opLui = 7'b0110111;
  localparam opcodeT opBranch = 7'b1100011;
  localparam opcodeT opJalr = 7'b1100111;
  localparam opcodeT opJal = 7'b1101111;

  // encoding format, picks the immediate layout and the operand routing
  typedef enum logic [2:0] {
    rFormat,
    iFormat,
    sFormat,
    bFormat,
    uFormat,
    jFormat,
    badFormat
  } instFormatT;

endpackage

// ==== source/execTypesPkg.sv ====
package execTypesPkg;

  // struct fields are sized for the widest core
  localparam int xlenMax = 64;

  typedef logic [xlenMax-1:0] wordT;
  typedef logic [7:0] storeMaskT;

  typedef enum logic [4:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd
  } aluOpT;

  typedef enum logic [1:0] {
    jumpNone,
    jumpJal,
    jumpJalr,
    jumpBranch
  } jumpKindT;

  // everything execute needs for one instruction
  typedef struct packed {
    wordT pc;
    decodeTypesPkg::instT inst;
    aluOpT aluOp;
    wordT aluRd1;
    wordT aluRd2;
    wordT rs2Data;
    wordT imm;
    decodeTypesPkg::regAddrT waddr;
    logic wen;
    logic readFlag;
    logic writeFlag;
    storeMaskT storeMask;
    logic jalrFlag;
    logic abort;
  } idexBundleT;

  // next-pc unit computes the target from these
  typedef struct packed {
    jumpKindT kind;
    wordT pc;
    wordT imm;
    wordT rs1Data;
  } npcRequestT;

  typedef struct packed {
    wordT data;
    logic pass1;
    logic pass2;
  } bypassT;

endpackage

// ==== source/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder #(
  parameter int xlen = 64
) (
  input  decodeTypesPkg::instT       inst,
  output decodeTypesPkg::instFormatT format,
  output logic [xlen-1:0]            imm,
  output execTypesPkg::aluOpT        aluOp,
  output logic                       wen,
  output logic                       readFlag,
  output logic                       writeFlag,
  output logic                       jalrFlag,
  output logic                       shamtFlag,
  output execTypesPkg::storeMaskT    storeMask
);
  import decodeTypesPkg::*;
  import execTypesPkg::*;

  opcodeT opcode;
  logic [2:0] func3;
  logic [6:0] func7;
  logic [xlen-1:0] immI;
  logic [xlen-1:0] immS;
  logic [xlen-1:0] immB;
  logic [xlen-1:0] immU;
  logic [xlen-1:0] immJ;
  aluOpT baseOp;

  assign opcode = inst[6:0];
  assign func3 = inst[14:12];
  assign func7 = inst[31:25];

  always_comb begin
    case (opcode)
      opReg: format = rFormat;
      opImm, opLoad, opJalr: format = iFormat;
      opStore: format = sFormat;
      opBranch: format = bFormat;
      opLui, opAuipc: format = uFormat;
      opJal: format = jFormat;
      default: format = badFormat;
    endcase
  end

  // all immediates take their sign from bit 31
  assign immI = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign immS = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
  assign immJ = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (format)
      iFormat: imm = immI;
      sFormat: imm = immS;
      bFormat: imm = immB;
      uFormat: imm = immU;
      jFormat: imm = immJ;
      default: imm = '0;
    endcase
  end

  // shared by register and immediate forms, bit 30 picks arithmetic shift
  always_comb begin
    case (func3)
      3'b000: baseOp = aluAdd;
      3'b001: baseOp = aluSll;
      3'b010: baseOp = aluSlt;
      3'b011: baseOp = aluSltu;
      3'b100: baseOp = aluXor;
      3'b101: baseOp = func7[5] ? aluSra : aluSrl;
      3'b110: baseOp = aluOr;
      default: baseOp = aluAnd;
    endcase
  end

  // loads, stores, jumps and upper immediates all just add
  always_comb begin
    aluOp = aluAdd;
    if (opcode == opReg || opcode == opImm) begin
      aluOp = baseOp;
      if (opcode == opReg && func3 == 3'b000 && func7[5]) begin
        aluOp = aluSub;
      end
    end
  end

  assign readFlag = opcode == opLoad;
  assign writeFlag = opcode == opStore;
  assign jalrFlag = opcode == opJalr;
  // slli, srli and srai
  assign shamtFlag = opcode == opImm && func3[1:0] == 2'b01;
  assign wen = opcode inside {opReg, opImm, opLoad, opLui, opAuipc, opJal, opJalr};

  always_comb begin
    storeMask = '0;
    if (writeFlag) begin
      case (func3[1:0])
        2'b00: storeMask = 8'h01;
        2'b01: storeMask = 8'h03;
        2'b10: storeMask = 8'h0f;
        default: storeMask = 8'hff;
      endcase
    end
  end

  // format and write enable come from separate opcode decodes
  always_comb begin
    assert final (!(format == badFormat && wen))
      else $error("write enable raised for unknown opcode %h", opcode);
  end

endmodule

// ==== source/issueControl.sv ====
`timescale 1ns/1ps

module issueControl #(
  parameter int xlen = 64
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     fetchValid,
  input  logic                     busy1,
  input  logic                     busy2,
  input  logic                     pass1,
  input  logic                     pass2,
  input  logic                     exReady,
  input  execTypesPkg::idexBundleT bundleIn,
  output logic                     ifReady,
  output logic                     npcValid,
  output logic                     sbValid,
  output logic                     sbWen,
  output execTypesPkg::idexBundleT idex,
  output logic                     idexValid
);

  logic stall;
  logic issue;

  // a busy source with nothing on the bypass has to wait
  assign stall = (busy1 && !pass1) || (busy2 && !pass2);
  assign issue = fetchValid && !stall && exReady;

  assign ifReady = exReady && !stall;
  assign npcValid = fetchValid && !stall;

  // scoreboard marks rd busy as the instruction leaves decode
  assign sbValid = fetchValid;
  assign sbWen = issue && bundleIn.wen;

  always_ff @(posedge clock) begin
    if (reset) begin
      idexValid <= 1'b0;
    end else if (issue) begin
      idexValid <= 1'b1;
    end else if (exReady) begin
      idexValid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      idex <= bundleIn;
    end
  end

  // execute may sample the bundle any time while it stalls
  assert property (@(posedge clock) disable iff (reset)
    idexValid && !exReady |=> $stable(idex))
    else $error("idex changed under back-pressure");

endmodule

// ==== source/operandSelect.sv ====
`timescale 1ns/1ps

module operandSelect #(
  parameter int xlen = 64
) (
  input  decodeTypesPkg::instFormatT format,
  input  decodeTypesPkg::opcodeT     opcode,
  input  logic [xlen-1:0]            pc,
  input  logic [xlen-1:0]            imm,
  input  logic                       shamtFlag,
  input  logic                       jalrFlag,
  input  logic [xlen-1:0]            regRdata1,
  input  logic [xlen-1:0]            regRdata2,
  input  logic                       busy1,
  input  logic                       busy2,
  input  execTypesPkg::bypassT       bypass,
  output logic [xlen-1:0]            rs1Data,
  output logic [xlen-1:0]            rs2Data,
  output logic [xlen-1:0]            aluRd1,
  output logic [xlen-1:0]            aluRd2
);
  import decodeTypesPkg::*;

  localparam int shamtWidth = $clog2(xlen);
  localparam logic [xlen-1:0] linkOffset = 4;

  logic [xlen-1:0] shamt;

  // forwarded data only counts for a busy register, so a write to x0
  // in flight never leaks into a read of x0
  assign rs1Data = (busy1 && bypass.pass1) ? bypass.data[xlen-1:0] : regRdata1;
  assign rs2Data = (busy2 && bypass.pass2) ? bypass.data[xlen-1:0] : regRdata2;

  // srai carries bit 30 in the immediate, strip it
  assign shamt = xlen'(imm[shamtWidth-1:0]);

  always_comb begin
    case (format)
      jFormat: begin
        aluRd1 = pc;
        aluRd2 = linkOffset;
      end
      iFormat: begin
        aluRd1 = jalrFlag ? pc : rs1Data;
        if (jalrFlag) begin
          aluRd2 = linkOffset;
        end else if (shamtFlag) begin
          aluRd2 = shamt;
        end else begin
          aluRd2 = imm;
        end
      end
      sFormat: begin
        aluRd1 = rs1Data;
        aluRd2 = imm;
      end
      uFormat: begin
        // lui adds to zero
        aluRd1 = (opcode == opAuipc) ? pc : '0;
        aluRd2 = imm;
      end
      rFormat: begin
        aluRd1 = rs1Data;
        aluRd2 = rs2Data;
      end
      default: begin
        aluRd1 = '0;
        aluRd2 = '0;
      end
    endcase
  end

endmodule

// ==== src.f ====
+incdir+verif
source/decodeTypesPkg.sv
source/execTypesPkg.sv
source/instDecoder.sv
source/operandSelect.sv
source/branchResolver.sv
source/issueControl.sv
source/decodeStage.sv
verif/decodeStageTb.sv

// ==== verif/decodeVectors.svh ====
`ifndef decodeVectorsSvh
`define decodeVectorsSvh

// columns per row: inst, pc, reg1, reg2, free, busy, pass, bypData, exReady,
// expImm, expAluOp, expRd1, expRd2, rdSrc, expWen, expAbort, expKind, expIfReady
typedef struct packed {
  instT inst;
  logic [63:0] pc;
  logic [63:0] reg1;
  logic [63:0] reg2;
  // register values come from $random
  logic free;
  // bit 1 for rs1, bit 0 for rs2
  logic [1:0] busy;
  logic [1:0] pass;
  logic [63:0] bypData;
  logic exReady;
  logic [63:0] expImm;
  aluOpT expAluOp;
  logic [63:0] expRd1;
  logic [63:0] expRd2;
  // bit 0 takes aluRd1 from the resolved rs1, bit 1 takes aluRd2 from rs2
  logic [1:0] rdSrc;
  logic expWen;
  logic expAbort;
  jumpKindT expKind;
  logic expIfReady;
} vectorRowT;

localparam int numRows = 27;
localparam logic [63:0] pcBase = 64'h0000_0000_8000_0100;
localparam logic [63:0] zeroWord = 64'h0;
localparam logic [63:0] linkWord = 64'h4;
localparam logic [63:0] regA = 64'h0123_4567_89ab_cdef;
localparam logic [63:0] regB = 64'hfedc_ba98_7654_3210;
localparam logic [63:0] allOnes = 64'hffff_ffff_ffff_ffff;
localparam logic [63:0] bypWord = 64'hdead_beef_0bad_f00d;

vectorRowT rows [numRows];

// instruction encoders, one per format
function automatic instT encR(input logic [6:0] f7, input regAddrT rs2, input regAddrT rs1,
                              input logic [2:0] f3, input regAddrT rd);
  return {f7, rs2, rs1, f3, rd, opReg};
endfunction

function automatic instT encI(input logic [11:0] imm, input regAddrT rs1, input logic [2:0] f3,
                              input regAddrT rd, input opcodeT op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic instT encS(input logic [11:0] imm, input regAddrT rs2, input regAddrT rs1,
                              input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
endfunction

function automatic instT encB(input logic [12:0] imm, input regAddrT rs2, input regAddrT rs1,
                              input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic instT encU(input logic [19:0] imm, input regAddrT rd, input opcodeT op);
  return {imm, rd, op};
endfunction

function automatic instT encJ(input logic [20:0] imm, input regAddrT rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

task automatic buildTable();
  // immediate forms, shifts take the shamt
  rows[0] = '{encI(12'hff9, 5'd1, 3'b000, 5'd5, opImm), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, 64'hffff_ffff_ffff_fff9,
    aluAdd, zeroWord, 64'hffff_ffff_ffff_fff9, 2'b01, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[1] = '{encI(12'h405, 5'd2, 3'b101, 5'd6, opImm), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, 64'h405,
    aluSra, zeroWord, 64'h5, 2'b01, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[2] = '{encI(12'h03f, 5'd3, 3'b001, 5'd7, opImm), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, 64'h3f,
    aluSll, zeroWord, 64'h3f, 2'b01, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[3] = '{encI(12'h7ff, 5'd1, 3'b011, 5'd8, opImm), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, 64'h7ff,
    aluSltu, zeroWord, 64'h7ff, 2'b01, 1'b1, 1'b0, jumpNone, 1'b1};
  // register forms
  rows[4] = '{encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, zeroWord,
    aluAdd, zeroWord, zeroWord, 2'b11, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[5] = '{encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd9), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, zeroWord,
    aluSub, zeroWord, zeroWord, 2'b11, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[6] = '{encR(7'h20, 5'd2, 5'd1, 3'b101, 5'd9), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, zeroWord,
    aluSra, zeroWord, zeroWord, 2'b11, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[7] = '{encR(7'h00, 5'd2, 5'd1, 3'b111, 5'd9), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, zeroWord,
    aluAnd, zeroWord, zeroWord, 2'b11, 1'b1, 1'b0, jumpNone, 1'b1};
  // load and store
  rows[8] = '{encI(12'hffc, 5'd2, 3'b010, 5'd10, opLoad), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, 64'hffff_ffff_ffff_fffc,
    aluAdd, zeroWord, 64'hffff_ffff_ffff_fffc, 2'b01, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[9] = '{encS(12'hff0, 5'd3, 5'd2, 3'b011), pcBase, zeroWord, zeroWord,
    1'b1, 2'b00, 2'b00, zeroWord, 1'b1, 64'hffff_ffff_ffff_fff0,
    aluAdd, zeroWord, 64'hffff_ffff_ffff_fff0, 2'b01, 1'b0, 1'b0, jumpNone, 1'b1};
  // upper immediates and jumps
  rows[10] = '{encU(20'h80000, 5'd11, opLui), pcBase, regA, regB,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'hffff_ffff_8000_0000,
    aluAdd, zeroWord, 64'hffff_ffff_8000_0000, 2'b00, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[11] = '{encU(20'h12345, 5'd12, opAuipc), pcBase, regA, regB,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'h1234_5000,
    aluAdd, pcBase, 64'h1234_5000, 2'b00, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[12] = '{encJ(21'h1ff800, 5'd1), pcBase, zeroWord, zeroWord,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'hffff_ffff_ffff_f800,
    aluAdd, pcBase, linkWord, 2'b00, 1'b1, 1'b0, jumpJal, 1'b1};
  rows[13] = '{encI(12'h00c, 5'd5, 3'b000, 5'd1, opJalr), pcBase, zeroWord, zeroWord,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'hc,
    aluAdd, pcBase, linkWord, 2'b00, 1'b1, 1'b0, jumpJalr, 1'b1};
  // branches, signed and unsigned compares
  rows[14] = '{encB(13'h1ff8, 5'd2, 5'd1, 3'b000), pcBase, regA, regA,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'hffff_ffff_ffff_fff8,
    aluAdd, zeroWord, zeroWord, 2'b00, 1'b0, 1'b0, jumpBranch, 1'b1};
  rows[15] = '{encB(13'h0010, 5'd2, 5'd1, 3'b001), pcBase, regA, regA,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'h10,
    aluAdd, zeroWord, zeroWord, 2'b00, 1'b0, 1'b0, jumpNone, 1'b1};
  rows[16] = '{encB(13'h0800, 5'd2, 5'd1, 3'b100), pcBase, allOnes, 64'h1,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'h800,
    aluAdd, zeroWord, zeroWord, 2'b00, 1'b0, 1'b0, jumpBranch, 1'b1};
  rows[17] = '{encB(13'h0ffe, 5'd2, 5'd1, 3'b110), pcBase, allOnes, 64'h1,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'hffe,
    aluAdd, zeroWord, zeroWord, 2'b00, 1'b0, 1'b0, jumpNone, 1'b1};
  rows[18] = '{encB(13'h1000, 5'd2, 5'd1, 3'b111), pcBase, allOnes, 64'h1,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'hffff_ffff_ffff_f000,
    aluAdd, zeroWord, zeroWord, 2'b00, 1'b0, 1'b0, jumpBranch, 1'b1};
  rows[19] = '{encB(13'h0020, 5'd2, 5'd1, 3'b101), pcBase, 64'h1, allOnes,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, 64'h20,
    aluAdd, zeroWord, zeroWord, 2'b00, 1'b0, 1'b0, jumpBranch, 1'b1};
  // bypass taken, then pass without busy
  rows[20] = '{encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), pcBase, regA, regB,
    1'b0, 2'b11, 2'b11, bypWord, 1'b1, zeroWord,
    aluAdd, bypWord, bypWord, 2'b00, 1'b1, 1'b0, jumpNone, 1'b1};
  rows[21] = '{encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), pcBase, regA, regB,
    1'b0, 2'b00, 2'b11, bypWord, 1'b1, zeroWord,
    aluAdd, regA, regB, 2'b00, 1'b1, 1'b0, jumpNone, 1'b1};
  // execute not ready for two cycles
  rows[22] = '{encI(12'h123, 5'd1, 3'b000, 5'd13, opImm), pcBase, regA, zeroWord,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b0, 64'h123,
    aluAdd, regA, 64'h123, 2'b00, 1'b1, 1'b0, jumpNone, 1'b0};
  rows[23] = '{encI(12'h0f0, 5'd2, 3'b110, 5'd14, opImm), pcBase, regB, zeroWord,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b0, 64'hf0,
    aluOr, regB, 64'hf0, 2'b00, 1'b1, 1'b0, jumpNone, 1'b0};
  // rs2 busy with nothing on the bypass
  rows[24] = '{encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), pcBase, regA, regB,
    1'b0, 2'b01, 2'b10, bypWord, 1'b1, zeroWord,
    aluAdd, regA, regB, 2'b00, 1'b1, 1'b0, jumpNone, 1'b0};
  // unknown opcodes
  rows[25] = '{32'h0000_007f, pcBase, zeroWord, zeroWord,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, zeroWord,
    aluAdd, zeroWord, zeroWord, 2'b00, 1'b0, 1'b1, jumpNone, 1'b1};
  rows[26] = '{32'habcd_e00b, pcBase, zeroWord, zeroWord,
    1'b0, 2'b00, 2'b00, zeroWord, 1'b1, zeroWord,
    aluAdd, zeroWord, zeroWord, 2'b00, 1'b0, 1'b1, jumpNone, 1'b1};
endtask

`endif

// ==== verif/decodeStageTb.sv ====
`timescale 1ns/1ps

module decodeStageTb;
  import decodeTypesPkg::*;
  import execTypesPkg::*;

  localparam int xlen = 64;

  logic clock;
  logic reset;
  instT inst;
  logic [xlen-1:0] pc;
  logic fetchValid;
  logic [xlen-1:0] regRdata1;
  logic [xlen-1:0] regRdata2;
  bypassT bypass;
  logic busy1;
  logic busy2;
  logic exReady;
  regAddrT raddr1;
  regAddrT raddr2;
  idexBundleT idex;
  logic idexValid;
  npcRequestT npcReq;
  logic npcValid;
  logic ifReady;
  logic sbValid;
  logic sbWen;
  regAddrT sbWaddr;

  `include "decodeVectors.svh"

  integer seed;
  int errorCount;
  int rowErrors;
  int failedTests;
  int testCount;
  string testName;

  // expected state of the ID/EX register
  logic expValid;
  vectorRowT lastRow;
  logic [63:0] lastRd1;
  logic [63:0] lastRd2;
  logic [63:0] lastRs2;

  // current row and the values derived from it
  vectorRowT row;
  logic [63:0] reg1;
  logic [63:0] reg2;
  logic [63:0] rs1;
  logic [63:0] rs2;
  logic [63:0] expRd1;
  logic [63:0] expRd2;
  logic stall;
  logic issue;

  decodeStage #(.xlen(xlen)) i_dut (
    .clock      (clock),
    .reset      (reset),
    .inst       (inst),
    .pc         (pc),
    .fetchValid (fetchValid),
    .regRdata1  (regRdata1),
    .regRdata2  (regRdata2),
    .bypass     (bypass),
    .busy1      (busy1),
    .busy2      (busy2),
    .exReady    (exReady),
    .raddr1     (raddr1),
    .raddr2     (raddr2),
    .idex       (idex),
    .idexValid  (idexValid),
    .npcReq     (npcReq),
    .npcValid   (npcValid),
    .ifReady    (ifReady),
    .sbValid    (sbValid),
    .sbWen      (sbWen),
    .sbWaddr    (sbWaddr)
  );

  always #50 clock = ~clock;

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] expected);
    if (got !== expected) begin
      $display("FAIL %s %s: got %h, expected %h", testName, name, got, expected);
      rowErrors++;
      errorCount++;
    end
  endtask

  // byte enables by access size, sb sh sw sd
  function automatic logic [7:0] storeMaskFor(input instT word);
    if (word[6:0] == opStore) begin
      return 8'hff >> (8 - (1 << word[13:12]));
    end else begin
      return 8'h00;
    end
  endfunction

  task automatic finishTest();
    testCount++;
    if (rowErrors == 0) begin
      $display("%s ok", testName);
    end else begin
      failedTests++;
      $display("%s had %0d mismatches", testName, rowErrors);
    end
    rowErrors = 0;
  endtask

  task automatic driveRow(input int index);
    row = rows[index];
    reg1 = row.reg1;
    reg2 = row.reg2;
    if (row.free) begin
      reg1 = {$random(seed), $random(seed)};
      reg2 = {$random(seed), $random(seed)};
    end
    // bypass only counts for a busy register
    rs1 = (row.busy[1] && row.pass[1]) ? row.bypData : reg1;
    rs2 = (row.busy[0] && row.pass[0]) ? row.bypData : reg2;
    expRd1 = row.rdSrc[0] ? rs1 : row.expRd1;
    expRd2 = row.rdSrc[1] ? rs2 : row.expRd2;
    stall = (row.busy[1] && !row.pass[1]) || (row.busy[0] && !row.pass[0]);
    issue = !stall && row.exReady;
    inst <= row.inst;
    pc <= row.pc;
    fetchValid <= 1'b1;
    regRdata1 <= reg1;
    regRdata2 <= reg2;
    busy1 <= row.busy[1];
    busy2 <= row.busy[0];
    bypass <= '{data: row.bypData, pass1: row.pass[1], pass2: row.pass[0]};
    exReady <= row.exReady;
  endtask

  // what the previous edges should have left in ID/EX
  task automatic checkPipeline();
    checkValue("idexValid", idexValid, expValid);
    if (expValid) begin
      checkValue("idex.inst", idex.inst, lastRow.inst);
      checkValue("idex.pc", idex.pc, lastRow.pc);
      checkValue("idex.imm", idex.imm, lastRow.expImm);
      checkValue("idex.aluOp", idex.aluOp, lastRow.expAluOp);
      checkValue("idex.aluRd1", idex.aluRd1, lastRd1);
      checkValue("idex.aluRd2", idex.aluRd2, lastRd2);
      checkValue("idex.rs2Data", idex.rs2Data, lastRs2);
      checkValue("idex.wen", idex.wen, lastRow.expWen);
      checkValue("idex.abort", idex.abort, lastRow.expAbort);
      checkValue("idex.waddr", idex.waddr, lastRow.inst[11:7]);
      checkValue("idex.readFlag", idex.readFlag, lastRow.inst[6:0] == opLoad);
      checkValue("idex.writeFlag", idex.writeFlag, lastRow.inst[6:0] == opStore);
      checkValue("idex.jalrFlag", idex.jalrFlag, lastRow.inst[6:0] == opJalr);
      checkValue("idex.storeMask", idex.storeMask, storeMaskFor(lastRow.inst));
    end
  endtask

  task automatic checkRow();
    checkValue("npcReq.imm", npcReq.imm, row.expImm);
    checkValue("npcReq.kind", npcReq.kind, row.expKind);
    checkValue("npcReq.pc", npcReq.pc, row.pc);
    checkValue("npcReq.rs1Data", npcReq.rs1Data, rs1);
    checkValue("aluOp", i_dut.bundle.aluOp, row.expAluOp);
    checkValue("aluRd1", i_dut.bundle.aluRd1, expRd1);
    checkValue("aluRd2", i_dut.bundle.aluRd2, expRd2);
    checkValue("wen", i_dut.bundle.wen, row.expWen);
    checkValue("abort", i_dut.bundle.abort, row.expAbort);
    checkValue("ifReady", ifReady, row.expIfReady);
    checkValue("npcValid", npcValid, !stall);
    checkValue("sbWen", sbWen, issue && row.expWen);
    checkValue("sbValid", sbValid, 1'b1);
    checkValue("sbWaddr", sbWaddr, row.inst[11:7]);
    checkValue("raddr1", raddr1, row.inst[19:15]);
    checkValue("raddr2", raddr2, row.inst[24:20]);
  endtask

  // register captures on issue, drains when execute takes it
  task automatic updateModel();
    if (issue) begin
      expValid = 1'b1;
      lastRow = row;
      lastRd1 = expRd1;
      lastRd2 = expRd2;
      lastRs2 = rs2;
    end else if (row.exReady) begin
      expValid = 1'b0;
    end
  endtask

  initial begin
    seed = 32'ha9c3_d808;
    errorCount = 0;
    rowErrors = 0;
    failedTests = 0;
    testCount = 0;
    expValid = 1'b0;
    clock = 1'b0;
    reset = 1'b1;
    inst = '0;
    pc = '0;
    fetchValid = 1'b0;
    regRdata1 = '0;
    regRdata2 = '0;
    bypass = '0;
    busy1 = 1'b0;
    busy2 = 1'b0;
    exReady = 1'b1;
    buildTable();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    testName = "reset";
    checkValue("idexValid", idexValid, 1'b0);
    checkValue("npcValid", npcValid, 1'b0);
    checkValue("sbWen", sbWen, 1'b0);
    checkValue("sbValid", sbValid, 1'b0);
    finishTest();
    for (int i = 0; i < numRows; i++) begin
      @(posedge clock);
      driveRow(i);
      @(negedge clock);
      testName = $sformatf("row %0d inst %h", i, rows[i].inst);
      checkPipeline();
      checkRow();
      updateModel();
      finishTest();
    end
    // one idle cycle to see the last bundle land
    @(posedge clock);
    fetchValid <= 1'b0;
    exReady <= 1'b1;
    @(negedge clock);
    testName = "drain";
    checkPipeline();
    checkValue("sbValid", sbValid, 1'b0);
    finishTest();
    $display("%0d tests run, %0d failed, %0d mismatches", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // generous bound, each row needs one cycle
  initial begin
    repeat (numRows * 4 + 20) @(posedge clock);
    $display("watchdog expired before the table was finished");
    $display("Simulation failed");
    $finish;
  end

endmodule
